/* run.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module cpuTb -Mdir obj_dir -o cpuSim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/cpuSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* sources.f */
+incdir+test
verilog/cpuPkg.sv
verilog/opcodeDispatch.sv
verilog/microcodeRom.sv
verilog/microSequencer.sv
verilog/flagAlu.sv
verilog/datapath.sv
verilog/cpuTop.sv
test/cpuTb.sv

/* test/cpuModel.svh */
////////////////////////////////////////////////////////////////////////////
// Random numbers and program generation
////////////////////////////////////////////////////////////////////////////

function automatic logic [31:0] nextRandom();
	rngState = rngState ^ (rngState << 13);
	rngState = rngState ^ (rngState >> 17);
	rngState = rngState ^ (rngState << 5);
	return rngState;
endfunction

// Register code 6 means (HL), so A stands in for it
function automatic logic [2:0] pickReg();
	logic [2:0] code;
	code = 3'(nextRandom() % 32'd7);
	if (code == 3'd6)
		code = 3'd7;
	return code;
endfunction

// Unkept opcodes run as NOP on the core
function automatic dataByte_t pickNop();
	dataByte_t code;
	case (nextRandom() % 32'd4)
		32'd0: code = OPC_NOP;
		32'd1: code = 8'h07;
		32'd2: code = 8'h2F;
		default: code = 8'hA0;
	endcase
	return code;
endfunction

function automatic dataByte_t dstForm(dataByte_t base, logic [2:0] code);
	return base | dataByte_t'({2'b00, code, 3'b000});
endfunction

function automatic dataByte_t srcForm(dataByte_t base, logic [2:0] code);
	return base | dataByte_t'({5'b00000, code});
endfunction

function automatic logic isDstForm(dataByte_t op, dataByte_t base);
	return ((op & 8'hC7) == base) && (op[5:3] != 3'd6);
endfunction

function automatic logic isSrcForm(dataByte_t op, dataByte_t base);
	return ((op & 8'hF8) == base) && (op[2:0] != 3'd6);
endfunction

task automatic emitByte(input dataByte_t value);
	mem[codePtr] = value;
	codePtr = codePtr + 16'd1;
endtask

// HL into the data page well above the code
task automatic emitLoadHl();
	dataByte_t offset;
	offset = 8'(nextRandom());
	emitByte(OPC_LD_HL_NN);
	emitByte(offset);
	emitByte(DATA_BASE[15:8]);
endtask

task automatic buildProgram();
	int a;
	int count;
	int kind;
	int gap;
	logic [2:0] r;
	addr_t target;
	dataByte_t base;
	for (a = 0; a < 65536; a++)
	begin
		mem[a] = 8'((a * 7) ^ (a >> 8) ^ 32'h0000005A);
		skipped[a] = 1'b0;
	end
	codePtr = '0;
	// Known values in every register first
	for (a = 0; a < 8; a++)
	begin
		if (a != 6)
		begin
			emitByte(dstForm(OPC_LD_R_N, 3'(a)));
			emitByte(8'(nextRandom()));
		end
	end
	count = 7;
	while (count < NUM_INSTR)
	begin
		kind = int'(nextRandom() % 32'd16);
		r = pickReg();
		if (kind == 0)
		begin
			emitByte(pickNop());
			count += 1;
		end
		else if (kind <= 2)
		begin
			emitByte(dstForm(OPC_LD_R_N, r));
			emitByte(8'(nextRandom()));
			count += 1;
		end
		else if (kind <= 6)
		begin
			// Stores of A show the ALU results
			emitLoadHl();
			if ((nextRandom() & 32'd1) != 32'd0)
				r = 3'd7;
			emitByte(srcForm(OPC_LD_HL_R, r));
			count += 2;
		end
		else if (kind == 7)
		begin
			emitLoadHl();
			emitByte(dstForm(OPC_LD_R_HL, r));
			count += 2;
		end
		else if (kind <= 9)
		begin
			base = ((nextRandom() & 32'd1) != 32'd0) ? OPC_INC_R : OPC_DEC_R;
			emitByte(dstForm(base, r));
			count += 1;
		end
		else if (kind == 10)
		begin
			// Forward jump over a few filler bytes
			gap = int'(nextRandom() % 32'd4);
			target = codePtr + addr_t'(3 + gap);
			emitByte(OPC_JP_NN);
			emitByte(target[7:0]);
			emitByte(target[15:8]);
			repeat (gap)
			begin
				skipped[codePtr] = 1'b1;
				emitByte(8'(nextRandom()));
			end
			count += 1;
		end
		else
		begin
			case (nextRandom() % 32'd4)
				32'd0: base = OPC_ADD_R;
				32'd1: base = OPC_ADC_R;
				32'd2: base = OPC_SUB_R;
				default: base = OPC_SBC_R;
			endcase
			emitByte(srcForm(base, r));
			count += 1;
		end
	end
	emitByte(OPC_HALT);
endtask

////////////////////////////////////////////////////////////////////////////
// Instruction-level reference model
////////////////////////////////////////////////////////////////////////////

task automatic runModel();
	int a;
	int wide;
	addr_t pc;
	addr_t hl;
	dataByte_t op;
	dataByte_t regs [8];
	logic carry;
	logic done;
	logic [2:0] dst;
	logic [2:0] src;
	for (a = 0; a < 65536; a++)
		modelMem[a] = mem[a];
	for (a = 0; a < 8; a++)
		regs[a] = 8'h00;
	pc = '0;
	carry = 1'b0;
	done = 1'b0;
	modelStoreCount = 0;
	while (!done)
	begin
		op = modelMem[pc];
		dst = op[5:3];
		src = op[2:0];
		hl = {regs[4], regs[5]};
		if (op == OPC_HALT)
		begin
			haltAddr = pc;
			done = 1'b1;
		end
		else if (op == OPC_LD_HL_NN || op == OPC_JP_NN)
		begin
			// JP goes through HL and leaves it there
			regs[5] = modelMem[pc + 16'd1];
			regs[4] = modelMem[pc + 16'd2];
			pc = (op == OPC_JP_NN) ? {regs[4], regs[5]} : pc + 16'd3;
		end
		else if (isDstForm(op, OPC_LD_R_N))
		begin
			regs[dst] = modelMem[pc + 16'd1];
			pc = pc + 16'd2;
		end
		else
		begin
			if (isDstForm(op, OPC_INC_R))
				regs[dst] = regs[dst] + 8'd1;
			else if (isDstForm(op, OPC_DEC_R))
				regs[dst] = regs[dst] - 8'd1;
			else if (isDstForm(op, OPC_LD_R_HL))
				regs[dst] = modelMem[hl];
			else if (isSrcForm(op, OPC_LD_HL_R))
			begin
				modelMem[hl] = regs[src];
				expAddrQ.push_back(hl);
				expDataQ.push_back(regs[src]);
				modelStoreCount++;
			end
			else if (isSrcForm(op, OPC_ADD_R) || isSrcForm(op, OPC_ADC_R)
				|| isSrcForm(op, OPC_SUB_R) || isSrcForm(op, OPC_SBC_R))
			begin
				wide = int'(regs[7]);
				if (isSrcForm(op, OPC_ADD_R) || isSrcForm(op, OPC_ADC_R))
					wide = wide + int'(regs[src]);
				else
					wide = wide - int'(regs[src]);
				if (isSrcForm(op, OPC_ADC_R))
					wide = wide + int'(carry);
				if (isSrcForm(op, OPC_SBC_R))
					wide = wide - int'(carry);
				// Carry out of bit 7, or borrow
				carry = (wide < 0) || (wide > 255);
				regs[7] = 8'(wide);
			end
			pc = pc + 16'd1;
		end
	end
endtask

/* test/cpuTb.sv */
`default_nettype none

module cpuTb
	import cpuPkg::*;
();

	localparam int NUM_INSTR = 200;
	localparam int MICRO_STEPS = 12;
	localparam int STALL_FACTOR = 4;
	localparam int MAX_CYCLES = NUM_INSTR * MICRO_STEPS * STALL_FACTOR;
	localparam addr_t DATA_BASE = 16'h8000;

	logic      clock;
	logic      reset;
	logic      memValid;
	logic      memReady;
	logic      memWrite;
	addr_t     memAddr;
	dataByte_t memWData;
	dataByte_t memRData;
	logic      halted;

	// Memory seen by the core, and the model's own copy
	dataByte_t   mem [65536];
	dataByte_t   modelMem [65536];
	logic        skipped [65536];
	addr_t       expAddrQ [$];
	dataByte_t   expDataQ [$];
	addr_t       haltAddr;
	addr_t       codePtr;
	addr_t       lastReadAddr;
	logic [31:0] rngState;
	int          modelStoreCount;
	int          storeCount;
	int          cycleCount;

	`include "cpuModel.svh"

	cpuTop cpuTop_inst (
		.clock    (clock),
		.reset    (reset),
		.memValid (memValid),
		.memReady (memReady),
		.memWrite (memWrite),
		.memAddr  (memAddr),
		.memWData (memWData),
		.memRData (memRData),
		.halted   (halted)
	);

	always #50 clock = ~clock;

	////////////////////////////////////////////////////////////////////////////
	// Error reporting
	////////////////////////////////////////////////////////////////////////////

	task automatic stopWithFailure();
		$display("*** FAILED ***");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("Mismatch at time %0t: %s, got %0h, expected %0h",
				$time, what, actual, expected);
			stopWithFailure();
		end
	endtask

	task automatic failWith(input string reason);
		$display("Error at time %0t: %s", $time, reason);
		stopWithFailure();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Memory responder, run on the falling edge
	////////////////////////////////////////////////////////////////////////////

	task automatic serviceMemory();
		logic ready;
		// Ready about two cycles in three
		ready = (nextRandom() % 32'd3) != 32'd0;
		memReady = ready;
		memRData = mem[memAddr];
		if (memValid && ready)
		begin
			if (memWrite)
			begin
				if (expAddrQ.size() == 0)
					failWith($sformatf("unexpected store to %h after the last one", memAddr));
				else
				begin
					checkEqual(32'(memAddr), 32'(expAddrQ.pop_front()), "store address");
					checkEqual(32'(memWData), 32'(expDataQ.pop_front()), "store data");
					mem[memAddr] = memWData;
					storeCount++;
				end
			end
			else if (skipped[memAddr])
				failWith($sformatf("read of skipped byte at %h", memAddr));
			else
				lastReadAddr = memAddr;
		end
	endtask

	initial
	begin
		clock = 1'b0;
		reset = 1'b1;
		memReady = 1'b0;
		memRData = 8'h00;
		rngState = 32'h39968462;
		storeCount = 0;
		cycleCount = 0;
		lastReadAddr = '0;
		buildProgram();
		runModel();

		repeat (8) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		while (!halted && cycleCount < MAX_CYCLES)
		begin
			serviceMemory();
			@(negedge clock);
			cycleCount++;
		end

		if (!halted)
			failWith($sformatf("the CPU never halted within %0d cycles", MAX_CYCLES));
		else
		begin
			// Core must stay quiet once halted
			repeat (8)
			begin
				serviceMemory();
				@(negedge clock);
				checkEqual(32'(memValid), 32'd0, "memValid after HALT");
				checkEqual(32'(halted), 32'd1, "halted after HALT");
			end
			checkEqual(32'(storeCount), 32'(modelStoreCount), "store count");
			checkEqual(32'(lastReadAddr), 32'(haltAddr), "address of the HALT fetch");
			$display("*** PASSED ***");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* verilog/cpuPkg.sv */
`default_nettype none

package cpuPkg;

	////////////////////////////////////////////////////////////////////////////
	// Data widths
	////////////////////////////////////////////////////////////////////////////
	typedef logic [7:0]  dataByte_t;
	typedef logic [15:0] addr_t;
	typedef logic [9:0]  uopAddr_t;
	typedef logic [14:0] uop_t;

	// Micro-instruction layout, sequencing field on top
	localparam int SEQ_W       = 3;
	localparam int OP_W        = 6;
	localparam int OPERAND_W   = 6;
	localparam int SEQ_LSB     = 12;
	localparam int OP_LSB      = 6;
	localparam int OPERAND_LSB = 0;

	// Bit 0 requests a PC increment, bit 1 ends the flow
	typedef enum logic [SEQ_W-1:0]
	{
		SEQ_STEP     = 3'd0,
		SEQ_STEP_INC = 3'd1,
		SEQ_EOF      = 3'd2,
		SEQ_EOF_INC  = 3'd3
	} seqCtrl_t;

	typedef enum logic [OP_W-1:0]
	{
		OP_NOP, OP_SET_MAR, OP_READ_MEM, OP_WRITE_MEM, OP_TO_SCRATCH,
		OP_ADD, OP_SUB, OP_ADC, OP_SBC, OP_FROM_SCRATCH,
		OP_INC, OP_DEC, OP_JUMP_HL, OP_HALT
	} uopOp_t;

	// Register operands follow the 3-bit register code of the opcode
	typedef enum logic [OPERAND_W-1:0]
	{
		OPD_B = 6'd0, OPD_C = 6'd1, OPD_D = 6'd2, OPD_E = 6'd3,
		OPD_H = 6'd4, OPD_L = 6'd5, OPD_HL = 6'd6, OPD_A = 6'd7,
		OPD_PC = 6'd8, OPD_SCRATCH = 6'd9, OPD_NONE = 6'd10
	} operand_t;

	// Register code that selects (HL) instead of a register
	localparam logic [2:0] CODE_HL = 3'd6;

	////////////////////////////////////////////////////////////////////////////
	// Opcodes, register fields cleared
	////////////////////////////////////////////////////////////////////////////
	localparam dataByte_t OPC_NOP      = 8'h00;
	localparam dataByte_t OPC_INC_R    = 8'h04;
	localparam dataByte_t OPC_DEC_R    = 8'h05;
	localparam dataByte_t OPC_LD_R_N   = 8'h06;
	localparam dataByte_t OPC_LD_HL_NN = 8'h21;
	localparam dataByte_t OPC_LD_R_HL  = 8'h46;
	localparam dataByte_t OPC_LD_HL_R  = 8'h70;
	localparam dataByte_t OPC_HALT     = 8'h76;
	localparam dataByte_t OPC_ADD_R    = 8'h80;
	localparam dataByte_t OPC_ADC_R    = 8'h88;
	localparam dataByte_t OPC_SUB_R    = 8'h90;
	localparam dataByte_t OPC_SBC_R    = 8'h98;
	localparam dataByte_t OPC_JP_NN    = 8'hC3;

	// Flow blocks of 32 words; register flows sit 4 words apart inside
	localparam uopAddr_t FLOW_FETCH    = 10'd0;
	localparam uopAddr_t FLOW_LD_R_N   = 10'd32;
	localparam uopAddr_t FLOW_LD_HL_R  = 10'd64;
	localparam uopAddr_t FLOW_LD_R_HL  = 10'd96;
	localparam uopAddr_t FLOW_ADD      = 10'd128;
	localparam uopAddr_t FLOW_ADC      = 10'd160;
	localparam uopAddr_t FLOW_SUB      = 10'd192;
	localparam uopAddr_t FLOW_SBC      = 10'd224;
	localparam uopAddr_t FLOW_INC      = 10'd256;
	localparam uopAddr_t FLOW_DEC      = 10'd288;
	localparam uopAddr_t FLOW_LD_HL_NN = 10'd320;
	localparam uopAddr_t FLOW_JP_NN    = 10'd352;
	localparam uopAddr_t FLOW_HALT     = 10'd384;

	// Start of the flow for one register of a family
	function automatic uopAddr_t regFlow(uopAddr_t base, logic [2:0] code);
		return base | uopAddr_t'({code, 2'b00});
	endfunction

endpackage

`default_nettype wire

/* verilog/cpuTop.sv */
`default_nettype none

module cpuTop
	import cpuPkg::*;
(
	input  logic      clock,
	input  logic      reset,
	output logic      memValid,
	input  logic      memReady,
	output logic      memWrite,
	output addr_t     memAddr,
	output dataByte_t memWData,
	input  dataByte_t memRData,
	output logic      halted
);

	uop_t      uop;
	uopAddr_t  uopAddr;
	uopAddr_t  flowStart;
	dataByte_t opcode;
	logic      memBusy;
	logic      step;

	microSequencer microSequencer_inst (
		.clock     (clock),
		.reset     (reset),
		.uop       (uop),
		.uopAddr   (uopAddr),
		.flowStart (flowStart),
		.opcode    (opcode),
		.memBusy   (memBusy),
		.memRData  (memRData),
		.step      (step)
	);

	opcodeDispatch opcodeDispatch_inst (
		.opcode    (opcode),
		.flowStart (flowStart)
	);

	microcodeRom microcodeRom_inst (
		.uopAddr (uopAddr),
		.uop     (uop)
	);

	// Bit 0 of the sequencing field asks for a PC increment
	datapath datapath_inst (
		.clock     (clock),
		.reset     (reset),
		.operation (uopOp_t'(uop[OP_LSB +: OP_W])),
		.operand   (operand_t'(uop[OPERAND_LSB +: OPERAND_W])),
		.incPc     (uop[SEQ_LSB]),
		.step      (step),
		.memValid  (memValid),
		.memReady  (memReady),
		.memWrite  (memWrite),
		.memAddr   (memAddr),
		.memWData  (memWData),
		.memRData  (memRData),
		.memBusy   (memBusy),
		.halted    (halted)
	);

endmodule

`default_nettype wire

/* verilog/datapath.sv */
`default_nettype none

module datapath
	import cpuPkg::*;
(
	input  logic      clock,
	input  logic      reset,
	input  uopOp_t    operation,
	input  operand_t  operand,
	input  logic      incPc,
	input  logic      step,
	output logic      memValid,
	input  logic      memReady,
	output logic      memWrite,
	output addr_t     memAddr,
	output dataByte_t memWData,
	input  dataByte_t memRData,
	output logic      memBusy,
	output logic      halted
);

	// Indexed by register code with slot 6 left empty
	dataByte_t  regs [8];
	dataByte_t  scratch;
	dataByte_t  srcValue;
	dataByte_t  aluResult;
	addr_t      pc;
	addr_t      mar;
	addr_t      hl;
	logic       zeroFlag;
	logic       carryFlag;
	logic       aluZero;
	logic       aluCarry;
	logic       isReg;
	logic [2:0] regIdx;

	assign isReg  = operand inside {OPD_A, OPD_B, OPD_C, OPD_D, OPD_E, OPD_H, OPD_L};
	assign regIdx = operand[2:0];
	assign hl     = {regs[3'(OPD_H)], regs[3'(OPD_L)]};

	always_comb
	begin
		if (isReg)
			srcValue = regs[regIdx];
		else if (operand == OPD_SCRATCH)
			srcValue = scratch;
		else
			srcValue = '0;
	end

	flagAlu flagAlu_inst (
		.operandA  (scratch),
		.operandB  (srcValue),
		.operation (operation),
		.carryIn   (carryFlag),
		.result    (aluResult),
		.zero      (aluZero),
		.carry     (aluCarry)
	);

	////////////////////////////////////////////////////////////////////////////
	// Memory port
	////////////////////////////////////////////////////////////////////////////
	assign memValid = (operation == OP_READ_MEM || operation == OP_WRITE_MEM) && !halted;
	assign memWrite = (operation == OP_WRITE_MEM);
	// Opcode fetch reads at PC, everything else at the address register
	assign memAddr  = (operand == OPD_PC) ? pc : mar;
	assign memWData = srcValue;
	// A halted core counts as permanently busy
	assign memBusy  = halted || (memValid && !memReady);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pc        <= '0;
			zeroFlag  <= 1'b0;
			carryFlag <= 1'b0;
			halted    <= 1'b0;
		end
		else if (step)
		begin
			if (incPc)
				pc <= pc + addr_t'(1);
			case (operation)
				OP_JUMP_HL: pc <= hl;
				OP_ADD, OP_SUB, OP_ADC, OP_SBC:
				begin
					zeroFlag  <= aluZero;
					carryFlag <= aluCarry;
				end
				// Carry survives inc and dec
				OP_INC, OP_DEC: zeroFlag <= aluZero;
				OP_HALT: halted <= 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (step)
		begin
			case (operation)
				OP_SET_MAR: mar <= (operand == OPD_HL) ? hl : pc;
				OP_READ_MEM: if (isReg) regs[regIdx] <= memRData;
				OP_TO_SCRATCH: scratch <= srcValue;
				OP_ADD, OP_SUB, OP_ADC, OP_SBC: scratch <= aluResult;
				OP_FROM_SCRATCH: if (isReg) regs[regIdx] <= scratch;
				OP_INC, OP_DEC: if (isReg) regs[regIdx] <= aluResult;
				default: ;
			endcase
		end
	end

	// Request held steady until memory accepts it
	assert property (@(posedge clock) disable iff (reset)
		(memValid && !memReady) |=> memValid && $stable(memAddr)
			&& $stable(memWrite) && $stable(memWData));

endmodule

`default_nettype wire

/* verilog/flagAlu.sv */
`default_nettype none

module flagAlu
	import cpuPkg::*;
(
	input  dataByte_t operandA,
	input  dataByte_t operandB,
	input  uopOp_t    operation,
	input  logic      carryIn,
	output dataByte_t result,
	output logic      zero,
	output logic      carry
);

	// Ninth bit holds carry out, or borrow on subtraction
	logic [8:0] wide;

	always_comb
	begin
		case (operation)
			OP_ADD:
				wide = {1'b0, operandA} + {1'b0, operandB};
			OP_ADC:
				wide = {1'b0, operandA} + {1'b0, operandB} + 9'(carryIn);
			OP_SUB:
				wide = {1'b0, operandA} - {1'b0, operandB};
			OP_SBC:
				wide = {1'b0, operandA} - {1'b0, operandB} - 9'(carryIn);
			// Inc and dec act on the register operand
			OP_INC:
				wide = {1'b0, operandB} + 9'd1;
			OP_DEC:
				wide = {1'b0, operandB} - 9'd1;
			default:
				wide = {1'b0, operandA};
		endcase
	end

	assign result = wide[7:0];
	assign zero   = (wide[7:0] == 8'h00);
	assign carry  = wide[8];

endmodule

`default_nettype wire

/* verilog/microSequencer.sv */
`default_nettype none

module microSequencer
	import cpuPkg::*;
(
	input  logic      clock,
	input  logic      reset,
	input  uop_t      uop,
	output uopAddr_t  uopAddr,
	input  uopAddr_t  flowStart,
	output dataByte_t opcode,
	input  logic      memBusy,
	input  dataByte_t memRData,
	output logic      step
);

	seqCtrl_t seq;
	logic     endOfFlow;
	uopAddr_t uPc;
	logic     dispatch;

	assign seq       = seqCtrl_t'(uop[SEQ_LSB +: SEQ_W]);
	assign endOfFlow = (seq == SEQ_EOF) || (seq == SEQ_EOF_INC);
	assign step      = !memBusy;

	// First word of a new flow comes straight from the dispatch table
	assign uopAddr = dispatch ? flowStart : uPc;

	////////////////////////////////////////////////////////////////////////////
	// Micro-program counter and opcode register
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			uPc      <= FLOW_FETCH;
			dispatch <= 1'b0;
			opcode   <= OPC_NOP;
		end
		else if (step)
		begin
			if (endOfFlow)
			begin
				// Last word fetched the next opcode at PC
				opcode   <= memRData;
				dispatch <= 1'b1;
			end
			else
			begin
				uPc      <= uopAddr + uopAddr_t'(1);
				dispatch <= 1'b0;
			end
		end
	end

	// Stalls and halt freeze the flow position
	assert property (@(posedge clock) disable iff (reset)
		memBusy |=> $stable(uopAddr));

endmodule

`default_nettype wire

/* verilog/microcodeRom.sv */
`default_nettype none

module microcodeRom
	import cpuPkg::*;
(
	input  uopAddr_t uopAddr,
	output uop_t     uop
);

	function automatic uop_t packUop(seqCtrl_t seq, uopOp_t op, operand_t opd);
		uop_t result;
		result = '0;
		result[SEQ_LSB +: SEQ_W] = seq;
		result[OP_LSB +: OP_W] = op;
		result[OPERAND_LSB +: OPERAND_W] = opd;
		return result;
	endfunction

	logic [4:0] family;
	logic [4:0] slot;
	logic [1:0] wordIdx;
	operand_t   regSel;
	uopOp_t     aluOp;
	uop_t       fetchUop;

	// Address fields for flow block, register code and word within the flow
	assign family   = uopAddr[9:5];
	assign slot     = uopAddr[4:0];
	assign wordIdx  = uopAddr[1:0];
	assign regSel   = operand_t'(OPERAND_W'(uopAddr[4:2]));

	// Closing word of every flow, and the whole NOP flow
	assign fetchUop = packUop(SEQ_EOF_INC, OP_READ_MEM, OPD_PC);

	always_comb
	begin
		case (family)
			FLOW_ADC[9:5]: aluOp = OP_ADC;
			FLOW_SUB[9:5]: aluOp = OP_SUB;
			FLOW_SBC[9:5]: aluOp = OP_SBC;
			default:       aluOp = OP_ADD;
		endcase
	end

	always_comb
	begin
		uop = fetchUop;
		case (family)
			FLOW_LD_R_N[9:5]:
				case (wordIdx)
					2'd0: uop = packUop(SEQ_STEP, OP_SET_MAR, OPD_PC);
					2'd1: uop = packUop(SEQ_STEP_INC, OP_READ_MEM, regSel);
					default: uop = fetchUop;
				endcase
			FLOW_LD_HL_R[9:5]:
				case (wordIdx)
					2'd0: uop = packUop(SEQ_STEP, OP_SET_MAR, OPD_HL);
					2'd1: uop = packUop(SEQ_STEP, OP_WRITE_MEM, regSel);
					default: uop = fetchUop;
				endcase
			FLOW_LD_R_HL[9:5]:
				case (wordIdx)
					2'd0: uop = packUop(SEQ_STEP, OP_SET_MAR, OPD_HL);
					2'd1: uop = packUop(SEQ_STEP, OP_READ_MEM, regSel);
					default: uop = fetchUop;
				endcase
			// A goes through scratch and back
			FLOW_ADD[9:5], FLOW_ADC[9:5], FLOW_SUB[9:5], FLOW_SBC[9:5]:
				case (wordIdx)
					2'd0: uop = packUop(SEQ_STEP, OP_TO_SCRATCH, OPD_A);
					2'd1: uop = packUop(SEQ_STEP, aluOp, regSel);
					2'd2: uop = packUop(SEQ_STEP, OP_FROM_SCRATCH, OPD_A);
					default: uop = fetchUop;
				endcase
			FLOW_INC[9:5], FLOW_DEC[9:5]:
				if (wordIdx == 2'd0)
					uop = packUop(SEQ_STEP, (family == FLOW_INC[9:5]) ? OP_INC : OP_DEC, regSel);
			FLOW_LD_HL_NN[9:5]:
				case (slot)
					5'd0: uop = packUop(SEQ_STEP, OP_SET_MAR, OPD_PC);
					5'd1: uop = packUop(SEQ_STEP_INC, OP_READ_MEM, OPD_L);
					5'd2: uop = packUop(SEQ_STEP, OP_SET_MAR, OPD_PC);
					5'd3: uop = packUop(SEQ_STEP_INC, OP_READ_MEM, OPD_H);
					default: uop = fetchUop;
				endcase
			// Target lands in HL first, then moves to PC
			FLOW_JP_NN[9:5]:
				case (slot)
					5'd0: uop = packUop(SEQ_STEP, OP_SET_MAR, OPD_PC);
					5'd1: uop = packUop(SEQ_STEP_INC, OP_READ_MEM, OPD_L);
					5'd2: uop = packUop(SEQ_STEP, OP_SET_MAR, OPD_PC);
					5'd3: uop = packUop(SEQ_STEP_INC, OP_READ_MEM, OPD_H);
					5'd4: uop = packUop(SEQ_STEP, OP_JUMP_HL, OPD_NONE);
					default: uop = fetchUop;
				endcase
			FLOW_HALT[9:5]:
				if (slot == 5'd0)
					uop = packUop(SEQ_STEP, OP_HALT, OPD_NONE);
			default:
				uop = fetchUop;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/opcodeDispatch.sv */
`default_nettype none

module opcodeDispatch
	import cpuPkg::*;
(
	input  dataByte_t opcode,
	output uopAddr_t  flowStart
);

	logic [2:0] dstCode;
	logic [2:0] srcCode;
	dataByte_t  dstClear;
	dataByte_t  srcClear;

	assign dstCode  = opcode[5:3];
	assign srcCode  = opcode[2:0];
	// Opcode with one register field masked off
	assign dstClear = opcode & 8'hC7;
	assign srcClear = opcode & 8'hF8;

	always_comb
	begin
		case (opcode)
			OPC_NOP:      flowStart = FLOW_FETCH;
			OPC_LD_HL_NN: flowStart = FLOW_LD_HL_NN;
			OPC_JP_NN:    flowStart = FLOW_JP_NN;
			OPC_HALT:     flowStart = FLOW_HALT;
			default:
			begin
				// The (HL) forms are not kept and run as NOP
				if (dstCode != CODE_HL && dstClear == OPC_LD_R_N)
					flowStart = regFlow(FLOW_LD_R_N, dstCode);
				else if (dstCode != CODE_HL && dstClear == OPC_LD_R_HL)
					flowStart = regFlow(FLOW_LD_R_HL, dstCode);
				else if (dstCode != CODE_HL && dstClear == OPC_INC_R)
					flowStart = regFlow(FLOW_INC, dstCode);
				else if (dstCode != CODE_HL && dstClear == OPC_DEC_R)
					flowStart = regFlow(FLOW_DEC, dstCode);
				else if (srcCode != CODE_HL && srcClear == OPC_LD_HL_R)
					flowStart = regFlow(FLOW_LD_HL_R, srcCode);
				else if (srcCode != CODE_HL && srcClear == OPC_ADD_R)
					flowStart = regFlow(FLOW_ADD, srcCode);
				else if (srcCode != CODE_HL && srcClear == OPC_ADC_R)
					flowStart = regFlow(FLOW_ADC, srcCode);
				else if (srcCode != CODE_HL && srcClear == OPC_SUB_R)
					flowStart = regFlow(FLOW_SUB, srcCode);
				else if (srcCode != CODE_HL && srcClear == OPC_SBC_R)
					flowStart = regFlow(FLOW_SBC, srcCode);
				else
					flowStart = FLOW_FETCH;
			end
		endcase
	end

endmodule

`default_nettype wire
